// ==== filelist.f ====
+incdir+common
common/lsu_pkg.sv
common/lsu_if.sv
hw/lsu/lsu_req_stage.sv
hw/lsu/lsu_mem_port.sv
hw/lsu/lsu_load_align.sv
hw/lsu/lsu_top.sv
test/lsu_tb.sv

// ==== Makefile ====
TOP = lsu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== test/lsu_tb.sv ====
// LSU testbench

`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam int          CLK_PERIOD = 8;
   localparam int          NUM_OPS    = 200;
   localparam int unsigned SEED       = 32'h8eba_8cf1;
   // 20 cycles per operation, plus reset and drain
   localparam int          TIMEOUT_NS = (NUM_OPS * 20 + 60) * CLK_PERIOD;

   typedef struct packed {
      lsu_addr_t vaddr;
      logic      ealign;
      lsu_word_t dout;
   } result_t;

   logic      clk;
   logic      arst_n;
   logic      flush;
   logic      ex_valid;
   lsu_op_t   ex_lsu_opc;
   lsu_addr_t add_sum;
   lsu_word_t ex_operand2;
   logic      lsu_stall_req;
   logic      mem_req;
   logic      mem_we;
   lsu_addr_t mem_addr;
   lsu_mask_t mem_wmsk;
   lsu_word_t mem_wdat;
   logic      mem_ack;
   lsu_word_t mem_rdat;
   logic      lsu_valid;
   logic      lsu_ealign;
   lsu_addr_t lsu_vaddr;
   lsu_word_t lsu_dout;

   lsu_word_t mem [lsu_addr_t];      // Responder storage
   lsu_word_t shadow [lsu_addr_t];   // Reference copy
   result_t   exp_q [$];
   result_t   exp_r;
   lsu_op_t   cur_op;                // Operation in flight
   lsu_addr_t cur_addr;
   lsu_mask_t cur_wmsk;
   lsu_word_t cur_wdat;
   logic      cur_mis;
   logic      ack_at_edge;
   logic      req_prev;

   lsu_top DUT (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input lsu_word_t got, input lsu_word_t exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input lsu_addr_t got, input lsu_addr_t exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_mask(input string name, input lsu_mask_t got, input lsu_mask_t exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   // Unwritten words read back a pattern of their own address
   function automatic lsu_word_t fill_word(input lsu_addr_t a);
      return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   function automatic lsu_word_t mem_rd(input lsu_addr_t a);
      return mem.exists(a) ? mem[a] : fill_word(a);
   endfunction

   function automatic lsu_word_t shadow_rd(input lsu_addr_t a);
      return shadow.exists(a) ? shadow[a] : fill_word(a);
   endfunction

   task automatic mem_write();
      lsu_word_t w;
      w = mem_rd(mem_addr);
      for (int i = 0; i < 4; i++) begin
         if (mem_wmsk[i]) w[i*8 +: 8] = mem_wdat[i*8 +: 8];
      end
      mem[mem_addr] = w;
   endtask

   // Reference model, called for each operation that the next edge accepts
   task automatic model_accept();
      lsu_word_t  w;
      lsu_word_t  d;
      lsu_addr_t  wa;
      logic [1:0] ln;
      logic [7:0] b;
      logic [15:0] h;
      result_t    r;
      d  = ex_operand2;
      ln = add_sum[1:0];
      wa = {add_sum[31:2], 2'b00};
      w  = shadow_rd(wa);
      b  = w[int'(ln) * 8 +: 8];
      h  = ln[1] ? w[31:16] : w[15:0];
      cur_op   = ex_lsu_opc;
      cur_addr = add_sum;
      cur_mis  = (ex_lsu_opc.size == SZ_WORD && ln != 2'b00) ||
                 (ex_lsu_opc.size == SZ_HALF && ln[0]);
      case (ex_lsu_opc.size)
         SZ_BYTE: begin
            cur_wdat = {4{d[7:0]}};
            cur_wmsk = 4'b0001 << ln;
         end
         SZ_HALF: begin
            cur_wdat = {2{d[15:0]}};
            cur_wmsk = ln[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            cur_wdat = d;
            cur_wmsk = 4'b1111;
         end
      endcase
      r.vaddr  = add_sum;
      r.ealign = cur_mis;
      r.dout   = '0;
      if (!cur_mis && ex_lsu_opc.store) begin
         case (ex_lsu_opc.size)
            SZ_BYTE: w[int'(ln) * 8 +: 8] = d[7:0];
            SZ_HALF: w[int'(ln[1]) * 16 +: 16] = d[15:0];
            default: w = d;
         endcase
         shadow[wa] = w;
      end else if (!cur_mis) begin
         case (ex_lsu_opc.size)
            SZ_BYTE: r.dout = {{24{ex_lsu_opc.sign_ext & b[7]}}, b};
            SZ_HALF: r.dout = {{16{ex_lsu_opc.sign_ext & h[15]}}, h};
            default: r.dout = w;
         endcase
      end
      exp_q.push_back(r);
   endtask

   task automatic check_request();
      if (exp_q.size() == 0) begin
         abort_run("mem_req was raised with no operation in flight");
      end else if (cur_mis) begin
         abort_run("mem_req was raised for a misaligned operation");
      end else begin
         check_addr("mem_addr", mem_addr, {cur_addr[31:2], 2'b00});
         check_flag("mem_we", mem_we, cur_op.store);
         if (cur_op.store) begin
            check_mask("mem_wmsk", mem_wmsk, cur_wmsk);
            check_word("mem_wdat", mem_wdat, cur_wdat);
         end
      end
   endtask

   // Memory side of the four-phase handshake
   initial begin
      mem_ack  = 1'b0;
      mem_rdat = '0;
      forever begin
         @(negedge clk);
         if (mem_req) begin
            check_request();
            repeat ($urandom_range(0, 5)) @(negedge clk);
            if (mem_we) mem_write();
            else mem_rdat = mem_rd(mem_addr);
            mem_ack = 1'b1;
            while (mem_req) @(negedge clk);
            repeat ($urandom_range(0, 5)) @(negedge clk);
            mem_ack  = 1'b0;
            mem_rdat = $urandom;   // Garbage outside the ack window
         end
      end
   end

   always @(posedge clk) ack_at_edge <= mem_ack;   // Ack as the DUT saw it

   initial req_prev = 1'b0;

   always @(negedge clk) begin
      if (arst_n) begin
         if (req_prev && !mem_req && !ack_at_edge) begin
            abort_run("mem_req fell before mem_ack rose");
         end
         if (!req_prev && mem_req && ack_at_edge) begin
            abort_run("mem_req rose while mem_ack was still high");
         end
      end
      req_prev = mem_req;
   end

   // Writeback results, in order
   always @(negedge clk) begin
      if (arst_n && lsu_valid) begin
         if (exp_q.size() == 0) begin
            abort_run("lsu_valid pulsed with no accepted operation outstanding");
         end else begin
            exp_r = exp_q.pop_front();
            check_addr("lsu_vaddr", lsu_vaddr, exp_r.vaddr);
            check_flag("lsu_ealign", lsu_ealign, exp_r.ealign);
            check_word("lsu_dout", lsu_dout, exp_r.dout);
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("The run timed out before all operations completed");
      $display("TESTBENCH FAILED");
      $fatal(1);
   end

   initial begin
      int          n_ops;
      int          kind;
      logic        took;
      logic [1:0]  lane;
      lsu_addr_t   base_a;
      void'($urandom(SEED));
      n_ops       = 0;
      took        = 1'b0;
      clk         = 1'b0;
      arst_n      = 1'b0;
      flush       = 1'b0;
      ex_valid    = 1'b0;
      ex_lsu_opc  = '0;
      add_sum     = '0;
      ex_operand2 = '0;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_flag("lsu_stall_req", lsu_stall_req, 1'b0);
      check_flag("mem_req", mem_req, 1'b0);
      check_flag("lsu_valid", lsu_valid, 1'b0);

      while (n_ops < NUM_OPS) begin
         @(negedge clk);
         if (took) check_flag("lsu_stall_req", lsu_stall_req, 1'b1);
         ex_valid = ($urandom % 4) != 0;
         flush    = ($urandom % 10) == 0;
         kind     = int'($urandom % 8);
         ex_lsu_opc.load     = kind < 4;
         ex_lsu_opc.store    = kind >= 4 && kind < 7;   // 7 is a non-memory op
         ex_lsu_opc.sign_ext = 1'($urandom % 2);
         ex_lsu_opc.size     = lsu_size_e'(3'($urandom_range(1, 3)));
         if ($urandom % 8 == 0) begin
            lane = 2'($urandom % 4);   // Possibly misaligned
         end else begin
            case (ex_lsu_opc.size)
               SZ_BYTE: lane = 2'($urandom % 4);
               SZ_HALF: lane = {1'($urandom % 2), 1'b0};
               default: lane = 2'b00;
            endcase
         end
         base_a      = 32'h0000_2000 + {26'b0, 4'($urandom % 16), 2'b00};
         add_sum     = {base_a[31:2], lane};
         ex_operand2 = $urandom;
         took = ex_valid && !flush && !lsu_stall_req && (ex_lsu_opc.load || ex_lsu_opc.store);
         if (took) begin
            model_accept();
            n_ops++;
         end
      end

      @(negedge clk);
      if (took) check_flag("lsu_stall_req", lsu_stall_req, 1'b1);
      ex_valid = 1'b0;
      flush    = 1'b0;
      while (exp_q.size() != 0) @(negedge clk);
      repeat (20) @(negedge clk);   // Any stray lsu_valid shows up here

      if (mem.num() != shadow.num()) begin
         abort_run("memory holds a different set of written words than the model");
      end
      foreach (shadow[a]) begin
         check_word("memory word", mem_rd(a), shadow[a]);
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== hw/lsu/lsu_top.sv ====
// Load/store unit top level

`timescale 1ns/1ps

module lsu_top (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                flush,
   input  logic                ex_valid,
   input  lsu_pkg::lsu_op_t    ex_lsu_opc,
   input  lsu_pkg::lsu_addr_t  add_sum,
   input  lsu_pkg::lsu_word_t  ex_operand2,
   output logic                lsu_stall_req,
   // Memory port
   output logic                mem_req,
   output logic                mem_we,
   output lsu_pkg::lsu_addr_t  mem_addr,
   output lsu_pkg::lsu_mask_t  mem_wmsk,
   output lsu_pkg::lsu_word_t  mem_wdat,
   input  logic                mem_ack,
   input  lsu_pkg::lsu_word_t  mem_rdat,
   // Writeback
   output logic                lsu_valid,
   output logic                lsu_ealign,
   output lsu_pkg::lsu_addr_t  lsu_vaddr,
   output lsu_pkg::lsu_word_t  lsu_dout
);

   lsu_req_if u_req_if ();
   lsu_rsp_if u_rsp_if ();

   lsu_req_stage u_req_stage (
      .clk            (clk),
      .arst_n         (arst_n),
      .flush          (flush),
      .ex_valid       (ex_valid),
      .ex_lsu_opc     (ex_lsu_opc),
      .add_sum        (add_sum),
      .ex_operand2    (ex_operand2),
      .lsu_stall_req  (lsu_stall_req),
      .req            (u_req_if.src)
   );

   lsu_mem_port u_mem_port (
      .clk            (clk),
      .arst_n         (arst_n),
      .req            (u_req_if.dst),
      .rsp            (u_rsp_if.src),
      .mem_req        (mem_req),
      .mem_we         (mem_we),
      .mem_addr       (mem_addr),
      .mem_wmsk       (mem_wmsk),
      .mem_wdat       (mem_wdat),
      .mem_ack        (mem_ack),
      .mem_rdat       (mem_rdat)
   );

   lsu_load_align u_load_align (
      .clk            (clk),
      .arst_n         (arst_n),
      .rsp            (u_rsp_if.dst),
      .lsu_valid      (lsu_valid),
      .lsu_ealign     (lsu_ealign),
      .lsu_vaddr      (lsu_vaddr),
      .lsu_dout       (lsu_dout)
   );

endmodule

// ==== hw/lsu/lsu_load_align.sv ====
// LSU load alignment and writeback register

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_load_align (
   input  logic                clk,
   input  logic                arst_n,
   lsu_rsp_if.dst              rsp,
   output logic                lsu_valid,
   output logic                lsu_ealign,
   output lsu_pkg::lsu_addr_t  lsu_vaddr,
   output lsu_pkg::lsu_word_t  lsu_dout
);
   import lsu_pkg::*;

   logic [`LSU_LANE_W-1:0] lane;
   logic [7:0]             byte_sel;
   logic [15:0]            half_sel;
   lsu_word_t              ext;
   lsu_word_t              dout_d;

   assign lane = rsp.vaddr[`LSU_LANE_W-1:0];

   // Lane pick
   assign byte_sel = rsp.rdat[{lane, 3'b000} +: 8];
   assign half_sel = lane[1] ? rsp.rdat[`LSU_DW-1:`LSU_DW/2] : rsp.rdat[`LSU_DW/2-1:0];

   always_comb begin
      case (rsp.op.size)
         SZ_BYTE: ext = {{(`LSU_DW-8){rsp.op.sign_ext & byte_sel[7]}}, byte_sel};
         SZ_HALF: ext = {{(`LSU_DW-16){rsp.op.sign_ext & half_sel[15]}}, half_sel};
         default: ext = rsp.rdat;   // Full word
      endcase
   end

   // Nothing to write back for stores or faults
   assign dout_d = (rsp.op.load && !rsp.ealign) ? ext : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lsu_valid <= 1'b0;
      end else begin
         lsu_valid <= rsp.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp.valid) begin
         lsu_ealign <= rsp.ealign;
         lsu_vaddr  <= rsp.vaddr;
         lsu_dout   <= dout_d;
      end
   end

   // Size code came through stage 1 untouched
   a_size_legal: assert property (@(posedge clk) disable iff (!arst_n)
      rsp.valid |-> rsp.op.size inside {SZ_BYTE, SZ_HALF, SZ_WORD});

endmodule

// ==== hw/lsu/lsu_mem_port.sv ====
// LSU memory port, four-phase req/ack master

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_mem_port (
   input  logic                clk,
   input  logic                arst_n,
   lsu_req_if.dst              req,
   lsu_rsp_if.src              rsp,
   output logic                mem_req,
   output logic                mem_we,
   output lsu_pkg::lsu_addr_t  mem_addr,
   output lsu_pkg::lsu_mask_t  mem_wmsk,
   output lsu_pkg::lsu_word_t  mem_wdat,
   input  logic                mem_ack,
   input  lsu_pkg::lsu_word_t  mem_rdat
);
   import lsu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_REQ,    // mem_req high, waiting for ack
      ST_REL,    // req dropped, waiting for ack release
      ST_DONE    // Completion pulse
   } state_e;

   state_e    state_q;
   state_e    state_d;
   lsu_word_t rdat_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (req.valid) begin
               state_d = req.misalign ? ST_DONE : ST_REQ;   // Misaligned skips memory
            end
         end
         ST_REQ: begin
            if (mem_ack) begin
               state_d = ST_REL;
            end
         end
         ST_REL: begin
            if (!mem_ack) begin
               state_d = ST_DONE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Read data is valid while ack is high
   always_ff @(posedge clk) begin
      if (state_q == ST_REQ && mem_ack && req.op.load) begin
         rdat_q <= mem_rdat;
      end
   end

   assign mem_req  = (state_q == ST_REQ);
   assign mem_we   = req.op.store;
   assign mem_addr = {req.vaddr[`LSU_AW-1:`LSU_LANE_W], {`LSU_LANE_W{1'b0}}};   // Word address
   assign mem_wmsk = req.wmsk;
   assign mem_wdat = req.wdat;

   assign req.done = (state_q == ST_DONE);

   // Request fields are still held during the done cycle
   assign rsp.valid  = (state_q == ST_DONE);
   assign rsp.ealign = req.misalign;
   assign rsp.op     = req.op;
   assign rsp.vaddr  = req.vaddr;
   assign rsp.rdat   = req.misalign ? '0 : rdat_q;

   // No new request while the previous ack is still up
   a_req_after_release: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(mem_req) |-> !$past(mem_ack));

   a_req_steady: assert property (@(posedge clk) disable iff (!arst_n)
      mem_req && $past(mem_req) |-> $stable({mem_we, mem_addr, mem_wmsk, mem_wdat}));

endmodule

// ==== hw/lsu/lsu_req_stage.sv ====
// LSU stage 1, decode and request register

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_req_stage (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                flush,
   input  logic                ex_valid,
   input  lsu_pkg::lsu_op_t    ex_lsu_opc,
   input  lsu_pkg::lsu_addr_t  add_sum,
   input  lsu_pkg::lsu_word_t  ex_operand2,
   output logic                lsu_stall_req,
   lsu_req_if.src              req
);
   import lsu_pkg::*;

   logic [`LSU_LANE_W-1:0] lane;
   logic                   s1_misalign;
   lsu_word_t              s1_wdat;
   lsu_mask_t              s1_wmsk;
   lsu_mask_t              msk_byte;
   lsu_mask_t              msk_half;
   logic                   accept;

   logic                   valid_q;
   logic                   pending_q;   // Writeback cycle after done
   logic                   misalign_q;
   lsu_op_t                op_q;
   lsu_addr_t              vaddr_q;
   lsu_mask_t              wmsk_q;
   lsu_word_t              wdat_q;

   assign lane = add_sum[`LSU_LANE_W-1:0];

   // Natural alignment per size
   assign s1_misalign = (ex_lsu_opc.size == SZ_WORD && lane != '0) ||
                        (ex_lsu_opc.size == SZ_HALF && lane[0]);

   // Store data replicated into every lane it could land in
   always_comb begin
      case (ex_lsu_opc.size)
         SZ_BYTE: s1_wdat = {`LSU_NB{ex_operand2[7:0]}};
         SZ_HALF: s1_wdat = {(`LSU_NB/2){ex_operand2[15:0]}};
         default: s1_wdat = ex_operand2;
      endcase
   end

   assign msk_byte = lsu_mask_t'(1) << lane;   // One-hot lane
   assign msk_half = lane[1] ? lsu_mask_t'(4'b1100) : lsu_mask_t'(4'b0011);

   always_comb begin
      s1_wmsk = '0;   // Loads write nothing
      if (ex_lsu_opc.store) begin
         case (ex_lsu_opc.size)
            SZ_BYTE: s1_wmsk = msk_byte;
            SZ_HALF: s1_wmsk = msk_half;
            SZ_WORD: s1_wmsk = '1;
            default: s1_wmsk = '0;
         endcase
      end
   end

   assign accept = ex_valid & ~flush & ~lsu_stall_req &
                   (ex_lsu_opc.load | ex_lsu_opc.store);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q   <= 1'b0;
         pending_q <= 1'b0;
      end else begin
         if (accept) begin
            valid_q <= 1'b1;
         end else if (req.done) begin
            valid_q <= 1'b0;
         end
         pending_q <= valid_q & req.done;
      end
   end

   // Request payload, loaded on acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         op_q       <= ex_lsu_opc;
         vaddr_q    <= add_sum;
         misalign_q <= s1_misalign;
         wmsk_q     <= s1_wmsk;
         wdat_q     <= s1_wdat;
      end
   end

   assign req.valid    = valid_q;
   assign req.misalign = misalign_q;
   assign req.op       = op_q;
   assign req.vaddr    = vaddr_q;
   assign req.wmsk     = wmsk_q;
   assign req.wdat     = wdat_q;

   // Busy from request through the writeback pulse
   assign lsu_stall_req = valid_q | pending_q;

   // Port must not finish a request that is not there
   a_done_valid: assert property (@(posedge clk) disable iff (!arst_n)
      req.done |-> req.valid);

endmodule

// ==== common/lsu_if.sv ====
// Internal LSU request and response links

`timescale 1ns/1ps

// Stage 1 request towards the memory port
interface lsu_req_if;
   import lsu_pkg::*;

   logic      valid;      // Held until done
   logic      misalign;
   lsu_op_t   op;
   lsu_addr_t vaddr;
   lsu_mask_t wmsk;
   lsu_word_t wdat;
   logic      done;       // One cycle, from the port

   modport src (
      output valid,
      output misalign,
      output op,
      output vaddr,
      output wmsk,
      output wdat,
      input  done
   );

   modport dst (
      input  valid,
      input  misalign,
      input  op,
      input  vaddr,
      input  wmsk,
      input  wdat,
      output done
   );
endinterface

// Completed access towards load alignment
interface lsu_rsp_if;
   import lsu_pkg::*;

   logic      valid;      // Single cycle pulse
   logic      ealign;
   lsu_op_t   op;
   lsu_addr_t vaddr;
   lsu_word_t rdat;       // Raw word, zero when misaligned

   modport src (
      output valid,
      output ealign,
      output op,
      output vaddr,
      output rdat
   );

   modport dst (
      input  valid,
      input  ealign,
      input  op,
      input  vaddr,
      input  rdat
   );
endinterface

// ==== common/lsu_pkg.sv ====
// Load/store unit shared types

`include "lsu_config.svh"

package lsu_pkg;

   // Access size, codes as issued by decode
   typedef enum logic [2:0] {
      SZ_BYTE = 3'd1,
      SZ_HALF = 3'd2,
      SZ_WORD = 3'd3
   } lsu_size_e;

   // Opcode bundle from execute
   typedef struct packed {
      logic      load;
      logic      store;
      logic      sign_ext;   // Only meaningful for byte and half loads
      lsu_size_e size;
   } lsu_op_t;

   typedef logic [`LSU_DW-1:0] lsu_word_t;
   typedef logic [`LSU_AW-1:0] lsu_addr_t;
   typedef logic [`LSU_NB-1:0] lsu_mask_t;   // One bit per byte lane

endpackage

// ==== common/lsu_config.svh ====
// Load/store unit width settings

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data word width
`define LSU_DW 32

// Address width
`define LSU_AW 32

// Byte lanes per data word
`define LSU_NB 4

// Lane index bits at the bottom of an address
`define LSU_LANE_W 2

`endif
